//--- verilog/drac_decode_pkg.sv
package drac_decode_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] bus64_t;
    typedef logic [4:0]      reg_addr_t;

    // major opcodes kept by this stage
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_ALU_I  = 7'b0010011;
    localparam logic [6:0] OP_ALU    = 7'b0110011;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LD  = 3'b011;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_LWU = 3'b110;

    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;
    localparam logic [2:0] F3_SD = 3'b011;

    // shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_NORMAL       = 7'b0000000;
    localparam logic [6:0] F7_SRAI_SUB_SRA = 7'b0100000;

    typedef enum logic [5:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LD, LBU, LHU, LWU,
        SB, SH, SW, SD
    } instr_type_e;

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_BRANCH,
        UNIT_MEM
    } unit_e;

    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        ILLEGAL_INSTR         = 4'd2,
        NONE                  = 4'd15
    } xcpt_cause_e;

    // one instruction word, read through each encoding format
    typedef union packed {
        struct packed {
            logic [6:0] func7;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] func3;
            reg_addr_t  rd;
            logic [6:0] opcode;
        } common;
        struct packed {
            logic [6:0] func7;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] func3;
            reg_addr_t  rd;
            logic [6:0] opcode;
        } rtype;
        struct packed {
            logic [11:0] imm;
            reg_addr_t   rs1;
            logic [2:0]  func3;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } itype;
        struct packed {
            logic [6:0] imm11_5;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] func3;
            logic [4:0] imm4_0;
            logic [6:0] opcode;
        } stype;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] func3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } btype;
        struct packed {
            logic [19:0] imm;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } utype;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            reg_addr_t  rd;
            logic [6:0] opcode;
        } jtype;
    } instr_u;

    typedef struct packed {
        logic        valid;
        xcpt_cause_e cause;
        bus64_t      origin;
    } exception_t;

    typedef struct packed {
        logic       valid;
        bus64_t     pc_inst;
        instr_u     inst;
        exception_t ex;
    } if_id_t;

    typedef struct packed {
        logic        regfile_we;
        logic        change_pc_ena;
        logic        use_imm;
        logic        use_pc;
        logic        zero_rs1;      // LUI reads x0
        instr_type_e instr_type;
        unit_e       unit;
        logic [2:0]  mem_size;
    } ctrl_t;

    typedef struct packed {
        logic       valid;
        bus64_t     pc;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        ctrl_t      ctrl;
        bus64_t     result;         // immediate
        exception_t ex;
    } id_entry_t;

    typedef struct packed {
        logic   valid;
        bus64_t jump_addr;
    } jal_redirect_t;

endpackage

//--- verilog/rv_imm_gen.sv
`timescale 1ns/100ps

module rv_imm_gen import drac_decode_pkg::*; (
    input  instr_u inst_i,
    output bus64_t imm_o
);

    always_comb begin
        case (inst_i.common.opcode)
            OP_LUI, OP_AUIPC: begin
                // upper 20 bits, low 12 cleared
                imm_o = {{(XLEN-32){inst_i.utype.imm[19]}}, inst_i.utype.imm, 12'b0};
            end
            OP_JAL: begin
                imm_o = {{(XLEN-21){inst_i.jtype.imm20}}, inst_i.jtype.imm20,
                         inst_i.jtype.imm19_12, inst_i.jtype.imm11,
                         inst_i.jtype.imm10_1, 1'b0};
            end
            OP_BRANCH: begin
                imm_o = {{(XLEN-13){inst_i.btype.imm12}}, inst_i.btype.imm12,
                         inst_i.btype.imm11, inst_i.btype.imm10_5,
                         inst_i.btype.imm4_1, 1'b0};
            end
            OP_STORE: begin
                imm_o = {{(XLEN-12){inst_i.stype.imm11_5[6]}}, inst_i.stype.imm11_5,
                         inst_i.stype.imm4_0};
            end
            default: begin // I format, also harmless for R type
                imm_o = {{(XLEN-12){inst_i.itype.imm[11]}}, inst_i.itype.imm};
            end
        endcase
    end

endmodule

//--- verilog/rv_opcode_decode.sv
`timescale 1ns/100ps

module rv_opcode_decode import drac_decode_pkg::*; (
    input  instr_u inst_i,
    input  logic   xcpt_in_i,
    input  logic   valid_i,
    output ctrl_t  ctrl_o,
    output logic   illegal_o
);

    always_comb begin
        ctrl_o.regfile_we    = 1'b0;
        ctrl_o.change_pc_ena = 1'b0;
        ctrl_o.use_imm       = 1'b0;
        ctrl_o.use_pc        = 1'b0;
        ctrl_o.zero_rs1      = 1'b0;
        ctrl_o.instr_type    = ADD;
        ctrl_o.unit          = UNIT_ALU;
        ctrl_o.mem_size      = inst_i.common.func3;   // size comes straight from funct3
        illegal_o            = 1'b0;

        if (valid_i && !xcpt_in_i) begin
            case (inst_i.common.opcode)
                OP_LUI: begin
                    ctrl_o.regfile_we = 1'b1;
                    ctrl_o.use_imm    = 1'b1;
                    ctrl_o.zero_rs1   = 1'b1;     // x0 | imm
                    ctrl_o.instr_type = OR;
                end
                OP_AUIPC: begin
                    ctrl_o.regfile_we = 1'b1;
                    ctrl_o.use_imm    = 1'b1;
                    ctrl_o.use_pc     = 1'b1;
                end
                OP_JAL: begin
                    // pc change happens here in decode, not later
                    ctrl_o.regfile_we = 1'b1;
                    ctrl_o.use_imm    = 1'b1;
                    ctrl_o.use_pc     = 1'b1;
                    ctrl_o.instr_type = JAL;
                    ctrl_o.unit       = UNIT_BRANCH;
                end
                OP_JALR: begin
                    ctrl_o.regfile_we    = 1'b1;
                    ctrl_o.change_pc_ena = 1'b1;
                    ctrl_o.use_imm       = 1'b1;
                    ctrl_o.use_pc        = 1'b1;
                    ctrl_o.instr_type    = JALR;
                    ctrl_o.unit          = UNIT_BRANCH;
                    illegal_o            = (inst_i.itype.func3 != 3'b000);
                end
                OP_BRANCH: begin
                    ctrl_o.change_pc_ena = 1'b1;
                    ctrl_o.use_imm       = 1'b1;
                    ctrl_o.use_pc        = 1'b1;
                    ctrl_o.unit          = UNIT_BRANCH;
                    case (inst_i.btype.func3)
                        F3_BEQ:  ctrl_o.instr_type = BEQ;
                        F3_BNE:  ctrl_o.instr_type = BNE;
                        F3_BLT:  ctrl_o.instr_type = BLT;
                        F3_BGE:  ctrl_o.instr_type = BGE;
                        F3_BLTU: ctrl_o.instr_type = BLTU;
                        F3_BGEU: ctrl_o.instr_type = BGEU;
                        default: illegal_o = 1'b1;
                    endcase
                end
                OP_LOAD: begin
                    ctrl_o.regfile_we = 1'b1;
                    ctrl_o.use_imm    = 1'b1;
                    ctrl_o.unit       = UNIT_MEM;
                    case (inst_i.itype.func3)
                        F3_LB:   ctrl_o.instr_type = LB;
                        F3_LH:   ctrl_o.instr_type = LH;
                        F3_LW:   ctrl_o.instr_type = LW;
                        F3_LD:   ctrl_o.instr_type = LD;
                        F3_LBU:  ctrl_o.instr_type = LBU;
                        F3_LHU:  ctrl_o.instr_type = LHU;
                        F3_LWU:  ctrl_o.instr_type = LWU;
                        default: illegal_o = 1'b1;
                    endcase
                end
                OP_STORE: begin
                    ctrl_o.use_imm = 1'b1;
                    ctrl_o.unit    = UNIT_MEM;
                    case (inst_i.stype.func3)
                        F3_SB:   ctrl_o.instr_type = SB;
                        F3_SH:   ctrl_o.instr_type = SH;
                        F3_SW:   ctrl_o.instr_type = SW;
                        F3_SD:   ctrl_o.instr_type = SD;
                        default: illegal_o = 1'b1;
                    endcase
                end
                OP_ALU_I: begin
                    ctrl_o.regfile_we = 1'b1;
                    ctrl_o.use_imm    = 1'b1;
                    // every funct3 is defined here
                    case (inst_i.itype.func3)
                        F3_ADD_SUB: ctrl_o.instr_type = ADD;
                        F3_SLT:     ctrl_o.instr_type = SLT;
                        F3_SLTU:    ctrl_o.instr_type = SLTU;
                        F3_XOR:     ctrl_o.instr_type = XOR;
                        F3_OR:      ctrl_o.instr_type = OR;
                        F3_AND:     ctrl_o.instr_type = AND;
                        F3_SLL: begin
                            ctrl_o.instr_type = SLL;
                            // shamt is 6 bits on RV64, so only func7[6:1] is checked
                            illegal_o = (inst_i.rtype.func7[6:1] != F7_NORMAL[6:1]);
                        end
                        F3_SRL_SRA: begin
                            if (inst_i.rtype.func7[6:1] == F7_SRAI_SUB_SRA[6:1]) begin
                                ctrl_o.instr_type = SRA;
                            end else if (inst_i.rtype.func7[6:1] == F7_NORMAL[6:1]) begin
                                ctrl_o.instr_type = SRL;
                            end else begin
                                illegal_o = 1'b1;
                            end
                        end
                    endcase
                end
                OP_ALU: begin
                    ctrl_o.regfile_we = 1'b1;
                    case ({inst_i.rtype.func7, inst_i.rtype.func3})
                        {F7_NORMAL, F3_ADD_SUB}:       ctrl_o.instr_type = ADD;
                        {F7_SRAI_SUB_SRA, F3_ADD_SUB}: ctrl_o.instr_type = SUB;
                        {F7_NORMAL, F3_SLL}:           ctrl_o.instr_type = SLL;
                        {F7_NORMAL, F3_SLT}:           ctrl_o.instr_type = SLT;
                        {F7_NORMAL, F3_SLTU}:          ctrl_o.instr_type = SLTU;
                        {F7_NORMAL, F3_XOR}:           ctrl_o.instr_type = XOR;
                        {F7_NORMAL, F3_SRL_SRA}:       ctrl_o.instr_type = SRL;
                        {F7_SRAI_SUB_SRA, F3_SRL_SRA}: ctrl_o.instr_type = SRA;
                        {F7_NORMAL, F3_OR}:            ctrl_o.instr_type = OR;
                        {F7_NORMAL, F3_AND}:           ctrl_o.instr_type = AND;
                        default:                       illegal_o = 1'b1;
                    endcase
                end
                default: begin
                    illegal_o = 1'b1;     // fence, system, amo, *W forms...
                end
            endcase
        end
    end

endmodule

//--- verilog/rv_jal_xcpt.sv
`timescale 1ns/100ps

module rv_jal_xcpt import drac_decode_pkg::*; (
    input  bus64_t        pc_i,
    input  bus64_t        imm_i,
    input  logic          is_jal_i,
    input  logic          illegal_i,
    input  exception_t    ex_i,
    output jal_redirect_t redirect_o,
    output exception_t    ex_o
);

    bus64_t target;
    logic   misaligned;

    assign target     = pc_i + imm_i;
    assign misaligned = is_jal_i & (|imm_i[1:0]);  // pc itself is assumed aligned

    assign redirect_o.valid     = is_jal_i & ~misaligned & ~ex_i.valid;
    assign redirect_o.jump_addr = is_jal_i ? target : '0;

    // fetch exception wins, then misaligned jump, then illegal
    always_comb begin
        if (ex_i.valid) begin
            ex_o = ex_i;
        end else if (misaligned) begin
            ex_o.valid  = 1'b1;
            ex_o.cause  = INSTR_ADDR_MISALIGNED;
            ex_o.origin = target;           // faulting target as hint
        end else if (illegal_i) begin
            ex_o.valid  = 1'b1;
            ex_o.cause  = ILLEGAL_INSTR;
            ex_o.origin = '0;
        end else begin
            ex_o.valid  = 1'b0;
            ex_o.cause  = NONE;
            ex_o.origin = '0;
        end
    end

endmodule

//--- verilog/id_stage.sv
`timescale 1ns/100ps

module id_stage import drac_decode_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  if_id_t        decode_i,
    output logic          ready_o,
    output id_entry_t     decode_instr_o,
    input  logic          ready_i,
    output jal_redirect_t jal_redirect_o
);

    bus64_t    imm;
    ctrl_t     ctrl;
    logic      illegal;
    logic      accept;
    logic      is_jal;
    id_entry_t entry_d;
    id_entry_t entry_q;

    assign ready_o = ~entry_q.valid | ready_i;    // empty, or the held entry leaves now
    assign accept  = decode_i.valid & ready_o;
    assign is_jal  = accept & (ctrl.instr_type == JAL);

    rv_imm_gen imm_gen_i (
        .inst_i (decode_i.inst),
        .imm_o  (imm)
    );

    rv_opcode_decode opcode_decode_i (
        .inst_i    (decode_i.inst),
        .xcpt_in_i (decode_i.ex.valid),
        .valid_i   (decode_i.valid),
        .ctrl_o    (ctrl),
        .illegal_o (illegal)
    );

    rv_jal_xcpt jal_xcpt_i (
        .pc_i       (decode_i.pc_inst),
        .imm_i      (imm),
        .is_jal_i   (is_jal),
        .illegal_i  (illegal),
        .ex_i       (decode_i.ex),
        .redirect_o (jal_redirect_o),
        .ex_o       (entry_d.ex)
    );

    assign entry_d.valid  = decode_i.valid;
    assign entry_d.pc     = decode_i.pc_inst;
    assign entry_d.rs1    = ctrl.zero_rs1 ? '0 : decode_i.inst.common.rs1;
    assign entry_d.rs2    = decode_i.inst.common.rs2;
    assign entry_d.rd     = decode_i.inst.common.rd;
    assign entry_d.ctrl   = ctrl;
    assign entry_d.result = imm;

    always_ff @(posedge clk_i, negedge rst_n_i) begin
        if (!rst_n_i) begin
            entry_q <= '0;
        end else if (accept) begin
            entry_q <= entry_d;
        end else if (ready_i) begin
            entry_q.valid <= 1'b0;    // drained, nothing new
        end
    end

    assign decode_instr_o = entry_q;

endmodule

//--- verification/tb_ref_decode.svh
`ifndef TB_REF_DECODE_SVH
`define TB_REF_DECODE_SVH

// operation per funct3 for OP with the normal funct7
localparam instr_type_e ALU_OPS [8] = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
localparam instr_type_e BRANCH_OPS [8] = '{BEQ, BNE, ADD, ADD, BLT, BGE, BLTU, BGEU};
localparam logic [7:0] BRANCH_OK = 8'b1111_0011;   // bit n set for a defined funct3 n

// sign-extend the low bits of v
function automatic bus64_t sext(input logic [31:0] v, input int bits);
    logic signed [63:0] t;
    t = {32'h0, v} << (64 - bits);
    return t >>> (64 - bits);
endfunction

function automatic void ref_decode(input if_id_t in, output id_entry_t e,
                                   output jal_redirect_t r);
    logic [31:0] w;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    bus64_t      imm;
    bus64_t      target;
    logic        bad;
    logic        jal;
    w   = in.inst;
    opc = w[6:0];
    f3  = w[14:12];
    f7  = w[31:25];
    case (opc)
        OP_LUI, OP_AUIPC: imm = sext({w[31:12], 12'h000}, 32);
        OP_JAL:           imm = sext({11'h0, w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
        OP_BRANCH:        imm = sext({19'h0, w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
        OP_STORE:         imm = sext({20'h0, w[31:25], w[11:7]}, 12);
        default:          imm = sext({20'h0, w[31:20]}, 12);
    endcase

    e                 = '0;
    e.ctrl.instr_type = ADD;
    e.ctrl.unit       = UNIT_ALU;
    e.ctrl.mem_size   = f3;
    bad               = 1'b0;
    if (in.valid && !in.ex.valid) begin
        e.ctrl.regfile_we    = opc inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD,
                                           OP_ALU_I, OP_ALU};
        e.ctrl.use_imm       = opc inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH,
                                           OP_LOAD, OP_STORE, OP_ALU_I};
        e.ctrl.use_pc        = opc inside {OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH};
        e.ctrl.change_pc_ena = opc inside {OP_JALR, OP_BRANCH};
        e.ctrl.zero_rs1      = (opc == OP_LUI);
        if (opc inside {OP_JAL, OP_JALR, OP_BRANCH}) begin
            e.ctrl.unit = UNIT_BRANCH;
        end else if (opc inside {OP_LOAD, OP_STORE}) begin
            e.ctrl.unit = UNIT_MEM;
        end
        case (opc)
            OP_LUI:   e.ctrl.instr_type = OR;
            OP_AUIPC: e.ctrl.instr_type = ADD;
            OP_JAL:   e.ctrl.instr_type = JAL;
            OP_JALR: begin
                e.ctrl.instr_type = JALR;
                bad = (f3 != 3'b000);
            end
            OP_BRANCH: begin
                e.ctrl.instr_type = BRANCH_OPS[f3];
                bad = !BRANCH_OK[f3];
            end
            OP_LOAD: begin
                bad = (f3 == 3'b111);
                e.ctrl.instr_type = bad ? ADD : instr_type_e'(LB + {3'b000, f3});
            end
            OP_STORE: begin
                bad = f3[2];
                e.ctrl.instr_type = bad ? ADD : instr_type_e'(SB + {3'b000, f3});
            end
            OP_ALU_I: begin
                e.ctrl.instr_type = ALU_OPS[f3];
                if (f3 == 3'b001) begin
                    bad = (f7[6:1] != 6'b000000);
                end else if (f3 == 3'b101 && f7[6:1] == 6'b010000) begin
                    e.ctrl.instr_type = SRA;
                end else if (f3 == 3'b101 && f7[6:1] != 6'b000000) begin
                    e.ctrl.instr_type = ADD;
                    bad = 1'b1;
                end
            end
            OP_ALU: begin
                if (f7 == 7'b0000000) begin
                    e.ctrl.instr_type = ALU_OPS[f3];
                end else if (f7 == 7'b0100000 && f3 == 3'b000) begin
                    e.ctrl.instr_type = SUB;
                end else if (f7 == 7'b0100000 && f3 == 3'b101) begin
                    e.ctrl.instr_type = SRA;
                end else begin
                    bad = 1'b1;
                end
            end
            default: bad = 1'b1;    // dropped opcode groups
        endcase
    end

    jal    = in.valid && !in.ex.valid && (opc == OP_JAL);
    target = in.pc_inst + imm;
    e.ex.cause = NONE;
    if (in.ex.valid) begin
        e.ex = in.ex;
    end else if (jal && imm[1:0] != 2'b00) begin
        e.ex.valid  = 1'b1;
        e.ex.cause  = INSTR_ADDR_MISALIGNED;
        e.ex.origin = target;
    end else if (bad) begin
        e.ex.valid = 1'b1;
        e.ex.cause = ILLEGAL_INSTR;
    end
    r.valid     = jal && (imm[1:0] == 2'b00);
    r.jump_addr = jal ? target : '0;

    e.valid  = in.valid;
    e.pc     = in.pc_inst;
    e.rs1    = e.ctrl.zero_rs1 ? 5'd0 : w[19:15];
    e.rs2    = w[24:20];
    e.rd     = w[11:7];
    e.result = imm;
endfunction

// instruction encoders, one per format
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

`endif

//--- verification/tb_id_stage.sv
`timescale 1ns/100ps

module tb_id_stage import drac_decode_pkg::*; ();

    localparam int NUM_TESTS       = 500;
    localparam int RESET_CYCLES    = 5;
    localparam int CLK_PERIOD      = 40;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 4 + RESET_CYCLES;

    logic          clk_i;
    logic          rst_n_i;
    if_id_t        decode_i;
    logic          ready_o;
    id_entry_t     decode_instr_o;
    logic          ready_i;
    jal_redirect_t jal_redirect_o;

    integer        seed;
    logic          checking;
    logic          exp_full;        // model of the output register
    logic          accept;
    id_entry_t     exp_entry;
    jal_redirect_t exp_redirect;
    id_entry_t     exp_q[$];

    `include "tb_ref_decode.svh"

    id_stage id_stage_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .decode_i       (decode_i),
        .ready_o        (ready_o),
        .decode_instr_o (decode_instr_o),
        .ready_i        (ready_i),
        .jal_redirect_o (jal_redirect_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic finish_failed();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        finish_failed();
    endtask

    task automatic report_mismatch(input string name, input bus64_t exp, input bus64_t got);
        $display("error at %0t: %s expected %0h got %0h", $time, name, exp, got);
        finish_failed();
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) report_mismatch(name, bus64_t'(exp), bus64_t'(got));
    endtask

    task automatic check_redirect(input jal_redirect_t got, input jal_redirect_t exp);
        if (got.valid !== exp.valid)
            report_mismatch("jal_redirect_o.valid", bus64_t'(exp.valid), bus64_t'(got.valid));
        if (got.jump_addr !== exp.jump_addr)
            report_mismatch("jal_redirect_o.jump_addr", exp.jump_addr, got.jump_addr);
    endtask

    task automatic check_entry(input id_entry_t got, input id_entry_t exp);
        if (got.pc !== exp.pc)
            report_mismatch("decode_instr_o.pc", exp.pc, got.pc);
        if (got.rs1 !== exp.rs1)
            report_mismatch("decode_instr_o.rs1", bus64_t'(exp.rs1), bus64_t'(got.rs1));
        if (got.rs2 !== exp.rs2)
            report_mismatch("decode_instr_o.rs2", bus64_t'(exp.rs2), bus64_t'(got.rs2));
        if (got.rd !== exp.rd)
            report_mismatch("decode_instr_o.rd", bus64_t'(exp.rd), bus64_t'(got.rd));
        if (got.ctrl.instr_type !== exp.ctrl.instr_type)
            report_mismatch("decode_instr_o.ctrl.instr_type",
                            bus64_t'(exp.ctrl.instr_type), bus64_t'(got.ctrl.instr_type));
        if (got.ctrl.unit !== exp.ctrl.unit)
            report_mismatch("decode_instr_o.ctrl.unit",
                            bus64_t'(exp.ctrl.unit), bus64_t'(got.ctrl.unit));
        if (got.ctrl.mem_size !== exp.ctrl.mem_size)
            report_mismatch("decode_instr_o.ctrl.mem_size",
                            bus64_t'(exp.ctrl.mem_size), bus64_t'(got.ctrl.mem_size));
        // the five enable bits together, named by the struct
        if (got.ctrl !== exp.ctrl)
            report_mismatch("decode_instr_o.ctrl", bus64_t'(exp.ctrl), bus64_t'(got.ctrl));
        if (got.result !== exp.result)
            report_mismatch("decode_instr_o.result", exp.result, got.result);
        if (got.ex.valid !== exp.ex.valid)
            report_mismatch("decode_instr_o.ex.valid",
                            bus64_t'(exp.ex.valid), bus64_t'(got.ex.valid));
        if (got.ex.cause !== exp.ex.cause)
            report_mismatch("decode_instr_o.ex.cause",
                            bus64_t'(exp.ex.cause), bus64_t'(got.ex.cause));
        if (got.ex.origin !== exp.ex.origin)
            report_mismatch("decode_instr_o.ex.origin", exp.ex.origin, got.ex.origin);
    endtask

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // ready_i high three times out of four
    function automatic logic ready_draw();
        logic [31:0] r;
        r = rand32();
        return r[1:0] != 2'b00;
    endfunction

    function automatic if_id_t make_item(input int kind);
        if_id_t      it;
        logic [31:0] r;
        logic [31:0] s;
        logic [6:0]  f7;
        logic [6:0]  opc;
        r          = rand32();
        s          = rand32();
        it         = '0;
        it.valid   = 1'b1;
        it.pc_inst = {rand32(), rand32()} & ~64'h3;   // fetch pc is word aligned
        it.ex.cause = NONE;
        case (kind)
            0: begin
                case (s[1:0])
                    2'd0, 2'd1: f7 = F7_NORMAL;
                    2'd2:       f7 = F7_SRAI_SUB_SRA;
                    default:    f7 = s[8:2];      // M extension and junk
                endcase
                it.inst = enc_r(f7, r[24:20], r[19:15], r[14:12], r[11:7], OP_ALU);
            end
            1: begin
                f7 = (s[1:0] == 2'b11) ? s[8:2] : {1'b0, s[0], 4'b0000, s[9]};
                it.inst = enc_i({f7, r[24:20]}, r[19:15], r[14:12], r[11:7], OP_ALU_I);
            end
            2: it.inst = enc_u(s[19:0], r[11:7], s[31] ? OP_LUI : OP_AUIPC);
            3: it.inst = enc_i(s[11:0], r[19:15], r[14:12], r[11:7], OP_LOAD);
            4: it.inst = enc_s(s[11:0], r[24:20], r[19:15], r[14:12]);
            5: it.inst = enc_b(s[12:0], r[24:20], r[19:15], r[14:12]);
            6: it.inst = enc_j(s[20:0], r[11:7]);
            7: it.inst = enc_i(s[11:0], r[19:15], s[31] ? 3'b000 : r[14:12], r[11:7],
                               OP_JALR);
            8: begin
                case (s[2:0])
                    3'd0:    opc = 7'b0001111;    // fence
                    3'd1:    opc = 7'b1110011;    // system
                    3'd2:    opc = 7'b0101111;    // amo
                    3'd3:    opc = 7'b0011011;    // op-imm-32
                    3'd4:    opc = 7'b0111011;    // op-32
                    default: opc = s[9:3];
                endcase
                it.inst = {r[31:7], opc};
            end
            default: begin
                // a JAL half the time, which would otherwise set enables and redirect
                it.inst      = s[1] ? {r[31:7], OP_JAL} : r;
                it.ex.valid  = 1'b1;
                it.ex.cause  = s[0] ? ILLEGAL_INSTR : INSTR_ADDR_MISALIGNED;
                it.ex.origin = it.pc_inst;
            end
        endcase
        return it;
    endfunction

    // present one item and hold it until the stage takes it
    task automatic send(input if_id_t item);
        if_id_t      idle;
        logic [31:0] r;
        r = rand32();
        idle = item;
        idle.valid = 1'b0;
        if (r[1:0] == 2'b00) begin
            @(posedge clk_i);
            decode_i <= idle;
            ready_i  <= ready_draw();
        end
        @(posedge clk_i);
        decode_i <= item;
        ready_i  <= ready_draw();
        @(negedge clk_i);
        while (!(decode_i.valid && ready_o)) begin
            @(posedge clk_i);
            ready_i <= ready_draw();
            @(negedge clk_i);
        end
    endtask

    // compare on the falling edge, where inputs and outputs are settled
    always @(negedge clk_i) begin
        if (checking) begin
            accept = decode_i.valid && ready_o;
            check_flag("ready_o", ready_o, !exp_full || ready_i);
            check_flag("decode_instr_o.valid", decode_instr_o.valid, exp_full);
            if (accept) begin
                ref_decode(decode_i, exp_entry, exp_redirect);
            end else begin
                exp_redirect = '0;
            end
            check_redirect(jal_redirect_o, exp_redirect);
            if (decode_instr_o.valid && ready_i) begin
                if (exp_q.size() == 0) abort_run("an entry left the stage with none expected");
                check_entry(decode_instr_o, exp_q.pop_front());
            end
            if (accept) exp_q.push_back(exp_entry);
            exp_full = accept || (exp_full && !ready_i);
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("timeout: the tests did not finish in the expected time");
    end

    initial begin
        seed     = 32'h6f4b_b70d;
        clk_i    = 1'b0;
        rst_n_i  = 1'b0;
        decode_i = '0;
        ready_i  = 1'b0;
        checking = 1'b0;
        exp_full = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i  <= 1'b1;
        checking <= 1'b1;
        repeat (3) @(posedge clk_i);    // output stays empty with nothing sent
        for (int i = 0; i < NUM_TESTS; i++) begin
            send(make_item(i % 10));
        end
        @(posedge clk_i);
        decode_i.valid <= 1'b0;
        ready_i        <= 1'b1;
        while (exp_q.size() != 0) @(negedge clk_i);
        @(negedge clk_i);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- drac_decode.f
+incdir+verification
verilog/drac_decode_pkg.sv
verilog/rv_imm_gen.sv
verilog/rv_opcode_decode.sv
verilog/rv_jal_xcpt.sv
verilog/id_stage.sv
verification/tb_id_stage.sv

//--- Makefile
SRCS = $(wildcard verilog/*.sv verification/*.sv verification/*.svh)

obj_dir/Vtb_id_stage: drac_decode.f $(SRCS)
	verilator --binary --timing --top-module tb_id_stage -f drac_decode.f -o Vtb_id_stage

run: obj_dir/Vtb_id_stage
	@out="$$(./obj_dir/Vtb_id_stage)"; echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean
